/* include/spi_flash_config.svh */
`ifndef SPI_FLASH_CONFIG_SVH
`define SPI_FLASH_CONFIG_SVH

// bit pacing, in CLK cycles.
`define SPI_TICKS_PER_BIT 8
`define SPI_SCK_RISE_TICK 4

// flash opcodes.
`define SPI_CMD_READ 8'h03
`define SPI_CMD_WAKE 8'hab

// host register offsets.
`define REG_ADDR_LO 8'h00
`define REG_ADDR_HI 8'h01
`define REG_CMD 8'h02
`define REG_DATA 8'h03
`define REG_STATUS 8'h04

`endif

/* hw/bus_pkg.sv */
package bus_pkg;

	// offset on the host register bus.
	typedef logic [7:0] reg_addr_t;

	// one host data word.
	typedef logic [15:0] reg_word_t;

endpackage

/* hw/spi_flash_pkg.sv */
package spi_flash_pkg;

	// halfword address, shifted left once for the byte address.
	typedef logic [22:0] word_addr_t;

	typedef logic [7:0] flash_byte_t;

	// wide enough for the 24 bit address phase.
	typedef logic [4:0] bit_count_t;

	typedef enum logic [2:0] {
		SEQ_IDLE = 3'd0,
		SEQ_OPCODE = 3'd1,
		SEQ_ADDRESS = 3'd2,
		SEQ_DATA = 3'd3,
		SEQ_DONE = 3'd4
	} seq_state_t;

endpackage

/* hw/spi_flash_ifs.sv */
`timescale 1ns/1ps

// host registers to sequencer.
interface spi_ctrl_if import bus_pkg::*, spi_flash_pkg::*; ();
	logic go;
	logic wake;
	word_addr_t word_addr;
	reg_word_t rx_data;
	logic done_pulse;

	modport regs (output go, wake, word_addr, input rx_data, done_pulse);
	modport seq (input go, wake, output rx_data, done_pulse);
endinterface

// phase strobes shared by sequencer, timer and shifter.
interface spi_phase_if import spi_flash_pkg::*; ();
	logic active;
	logic restart;
	logic load_opcode;
	logic load_address;
	flash_byte_t opcode;
	logic sck_rise;
	logic bit_end;
	bit_count_t bit_index;

	modport seq (
		output active, restart, load_opcode, load_address, opcode,
		input bit_end, bit_index
	);
	modport timer (input active, restart, output sck_rise, bit_end, bit_index);
	modport shift (
		input active, restart, load_opcode, load_address, opcode, sck_rise, bit_end
	);
endinterface

/* hw/spi_regs.sv */
`timescale 1ns/1ps
`include "spi_flash_config.svh"

module spi_regs
	import bus_pkg::*;
(
	input logic CLK,
	input logic RSTb,
	input reg_addr_t address,
	input reg_word_t data_in,
	input logic wr,
	output reg_word_t data_out,
	input logic busy,
	spi_ctrl_if.regs ctrl
);

	reg_word_t addr_lo;
	logic [6:0] addr_hi;
	reg_word_t rx_halfword;
	logic done;
	logic cmd_wr;
	logic busy_any;

	// a pending strobe counts as busy too.
	assign busy_any = busy | ctrl.go | ctrl.wake;

	assign cmd_wr = wr && (address == `REG_CMD) && !busy_any;

	assign ctrl.word_addr = {addr_hi, addr_lo};

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			addr_lo <= '0;
			addr_hi <= '0;
			ctrl.go <= 1'b0;
			ctrl.wake <= 1'b0;
			done <= 1'b0;
			rx_halfword <= '0;
		end else begin
			ctrl.go <= cmd_wr && data_in[0];
			ctrl.wake <= cmd_wr && data_in[1];
			if (wr && address == `REG_ADDR_LO) begin
				addr_lo <= data_in;
			end
			if (wr && address == `REG_ADDR_HI) begin
				addr_hi <= data_in[6:0];
			end
			// cleared on the accepting edge so a poll never sees stale done.
			if (cmd_wr && (data_in[0] || data_in[1])) begin
				done <= 1'b0;
			end else if (ctrl.done_pulse) begin
				done <= 1'b1;
			end
			if (ctrl.done_pulse) begin
				rx_halfword <= ctrl.rx_data;
			end
		end
	end

	always_comb begin
		case (address)
			`REG_DATA: begin
				// first byte on the wire goes low.
				data_out = {rx_halfword[7:0], rx_halfword[15:8]};
			end
			`REG_STATUS: begin
				data_out = {14'd0, busy_any, done};
			end
			default: begin
				data_out = '0;
			end
		endcase
	end

endmodule

/* hw/spi_sequencer.sv */
`timescale 1ns/1ps
`include "spi_flash_config.svh"

module spi_sequencer
	import bus_pkg::*;
	import spi_flash_pkg::*;
(
	input logic CLK,
	input logic RSTb,
	spi_ctrl_if.seq ctrl,
	spi_phase_if.seq phase,
	input reg_word_t rx_word,
	output logic busy
);

	// last bit index of each phase.
	localparam bit_count_t OPCODE_LAST = 5'd7;
	localparam bit_count_t ADDRESS_LAST = 5'd23;
	localparam bit_count_t DATA_LAST = 5'd15;

	seq_state_t state;
	seq_state_t state_next;
	logic wake_op;

	// read wins when both strobes are set.
	assign phase.opcode = ctrl.go ? `SPI_CMD_READ : `SPI_CMD_WAKE;

	assign busy = (state != SEQ_IDLE);
	assign ctrl.done_pulse = (state == SEQ_DONE);
	assign ctrl.rx_data = rx_word;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= SEQ_IDLE;
			wake_op <= 1'b0;
		end else begin
			state <= state_next;
			if (phase.load_opcode) begin
				wake_op <= !ctrl.go;
			end
		end
	end

	always_comb begin
		state_next = state;
		phase.active = 1'b0;
		phase.restart = 1'b0;
		phase.load_opcode = 1'b0;
		phase.load_address = 1'b0;
		case (state)
			SEQ_IDLE: begin
				// active already here so CSb falls on the next edge.
				if (ctrl.go || ctrl.wake) begin
					phase.active = 1'b1;
					phase.restart = 1'b1;
					phase.load_opcode = 1'b1;
					state_next = SEQ_OPCODE;
				end
			end
			SEQ_OPCODE: begin
				phase.active = 1'b1;
				if (phase.bit_end && phase.bit_index == OPCODE_LAST) begin
					if (wake_op) begin
						state_next = SEQ_DONE;
					end else begin
						phase.restart = 1'b1;
						phase.load_address = 1'b1;
						state_next = SEQ_ADDRESS;
					end
				end
			end
			SEQ_ADDRESS: begin
				phase.active = 1'b1;
				if (phase.bit_end && phase.bit_index == ADDRESS_LAST) begin
					phase.restart = 1'b1;
					state_next = SEQ_DATA;
				end
			end
			SEQ_DATA: begin
				phase.active = 1'b1;
				if (phase.bit_end && phase.bit_index == DATA_LAST) begin
					state_next = SEQ_DONE;
				end
			end
			SEQ_DONE: begin
				state_next = SEQ_IDLE;
			end
			default: begin
				state_next = SEQ_IDLE;
			end
		endcase
	end

endmodule

/* hw/spi_bit_timer.sv */
`timescale 1ns/1ps
`include "spi_flash_config.svh"

module spi_bit_timer
	import spi_flash_pkg::*;
(
	input logic CLK,
	input logic RSTb,
	spi_phase_if.timer phase
);

	localparam int TICK_W = $clog2(`SPI_TICKS_PER_BIT);
	localparam logic [TICK_W-1:0] RISE_TICK = TICK_W'(`SPI_SCK_RISE_TICK);
	localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(`SPI_TICKS_PER_BIT - 1);

	logic [TICK_W-1:0] tick;
	bit_count_t bit_index;

	assign phase.sck_rise = phase.active && (tick == RISE_TICK);
	assign phase.bit_end = phase.active && (tick == LAST_TICK);
	assign phase.bit_index = bit_index;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			tick <= '0;
			bit_index <= '0;
		end else if (phase.restart) begin
			tick <= '0;
			bit_index <= '0;
		end else if (phase.active) begin
			// tick wraps to zero at the end of each bit.
			tick <= tick + 1'b1;
			if (tick == LAST_TICK) begin
				bit_index <= bit_index + 1'b1;
			end
		end
	end

endmodule

/* hw/spi_shifter.sv */
`timescale 1ns/1ps

module spi_shifter
	import bus_pkg::*;
	import spi_flash_pkg::*;
(
	input logic CLK,
	input logic RSTb,
	spi_phase_if.shift phase,
	input word_addr_t word_addr,
	input logic miso,
	output logic mosi,
	output logic sck,
	output logic csb,
	output reg_word_t rx_word
);

	localparam int SHIFT_W = $bits(word_addr_t) + 1;
	localparam int PAD_W = SHIFT_W - $bits(flash_byte_t);

	logic [SHIFT_W-1:0] shift_q;
	logic rx_phase;

	assign mosi = shift_q[SHIFT_W-1];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			shift_q <= '0;
			rx_phase <= 1'b0;
			rx_word <= '0;
			sck <= 1'b0;
			csb <= 1'b1;
		end else begin
			csb <= !phase.active;

			if (phase.load_opcode) begin
				shift_q <= {phase.opcode, {PAD_W{1'b0}}};
			end else if (phase.load_address) begin
				// byte address is twice the halfword address.
				shift_q <= {word_addr, 1'b0};
			end else if (phase.bit_end) begin
				shift_q <= {shift_q[SHIFT_W-2:0], 1'b0};
			end

			// a restart with no load opens the data phase.
			if (phase.load_opcode) begin
				rx_phase <= 1'b0;
			end else if (phase.restart && !phase.load_address) begin
				rx_phase <= 1'b1;
			end

			if (phase.sck_rise && rx_phase) begin
				rx_word <= {rx_word[$bits(reg_word_t)-2:0], miso};
			end

			if (phase.bit_end) begin
				sck <= 1'b0;
			end else if (phase.sck_rise) begin
				sck <= 1'b1;
			end
		end
	end

endmodule

/* hw/spi_flash.sv */
`timescale 1ns/1ps

module spi_flash
	import bus_pkg::*;
(
	input logic CLK,
	input logic RSTb,
	input reg_addr_t ADDRESS,
	input reg_word_t DATA_IN,
	output reg_word_t DATA_OUT,
	input logic WR,
	output logic MOSI,
	input logic MISO,
	output logic SCK,
	output logic CSb
);

	spi_ctrl_if ctrl_bus ();
	spi_phase_if phase_bus ();

	reg_word_t rx_word;
	logic busy;

	spi_regs u_regs (
		.CLK(CLK),
		.RSTb(RSTb),
		.address(ADDRESS),
		.data_in(DATA_IN),
		.wr(WR),
		.data_out(DATA_OUT),
		.busy(busy),
		.ctrl(ctrl_bus.regs)
	);

	spi_sequencer u_sequencer (
		.CLK(CLK),
		.RSTb(RSTb),
		.ctrl(ctrl_bus.seq),
		.phase(phase_bus.seq),
		.rx_word(rx_word),
		.busy(busy)
	);

	spi_bit_timer u_bit_timer (
		.CLK(CLK),
		.RSTb(RSTb),
		.phase(phase_bus.timer)
	);

	spi_shifter u_shifter (
		.CLK(CLK),
		.RSTb(RSTb),
		.phase(phase_bus.shift),
		.word_addr(ctrl_bus.word_addr),
		.miso(MISO),
		.mosi(MOSI),
		.sck(SCK),
		.csb(CSb),
		.rx_word(rx_word)
	);

endmodule

/* tb/flash_model.sv */
`timescale 1ns/1ps

module flash_model #(
	parameter logic [31:0] SEED = 32'h0
) (
	input logic sck,
	input logic csb,
	input logic mosi,
	output logic miso,
	output int frame_count,
	output logic [7:0] last_opcode,
	output logic [23:0] last_addr,
	output int last_bits,
	output logic [15:0] last_data
);

	localparam logic [7:0] READ_OPCODE = 8'h03;

	logic [7:0] mem [logic [23:0]];
	logic [31:0] seed;
	logic [31:0] rx_shift;
	logic [15:0] tx_shift;
	logic [7:0] opcode;
	logic [23:0] addr;
	logic [15:0] data;
	logic [7:0] byte_lo;
	logic [7:0] byte_hi;
	logic sck_q;
	logic csb_q;
	logic in_frame;
	int bits;

	// bytes appear on first access.
	function automatic logic [7:0] mem_byte(input logic [23:0] a);
		logic [31:0] r;
		if (!mem.exists(a)) begin
			r = $random(seed);
			mem[a] = r[7:0];
		end
		return mem[a];
	endfunction

	initial begin
		seed = SEED;
		miso = 1'b0;
		frame_count = 0;
		last_opcode = '0;
		last_addr = '0;
		last_bits = 0;
		last_data = '0;
		rx_shift = '0;
		tx_shift = '0;
		opcode = '0;
		addr = '0;
		data = '0;
		sck_q = 1'b0;
		csb_q = 1'b1;
		in_frame = 1'b0;
		bits = 0;
		forever begin
			@(sck or csb);
			if (csb_q && !csb) begin
				in_frame = 1'b1;
				bits = 0;
				rx_shift = '0;
				opcode = '0;
				addr = '0;
				data = '0;
			end else if (!csb_q && csb && in_frame) begin
				in_frame = 1'b0;
				frame_count = frame_count + 1;
				last_opcode = opcode;
				last_addr = addr;
				last_bits = bits;
				last_data = data;
			end
			if (in_frame && !csb) begin
				if (!sck_q && sck) begin
					// mode 0, sampled on the rising edge.
					rx_shift = {rx_shift[30:0], mosi};
					bits = bits + 1;
					if (bits == 8) begin
						opcode = rx_shift[7:0];
					end
					if (bits == 32) begin
						addr = rx_shift[23:0];
						byte_lo = mem_byte(addr);
						byte_hi = mem_byte(addr + 24'd1);
						data = {byte_hi, byte_lo};
						tx_shift = {byte_lo, byte_hi};
					end
				end else if (sck_q && !sck && bits >= 32 && opcode == READ_OPCODE) begin
					miso = tx_shift[15];
					tx_shift = {tx_shift[14:0], 1'b0};
				end
			end
			sck_q = sck;
			csb_q = csb;
		end
	end

endmodule

/* tb/tb_spi_flash.sv */
`timescale 1ns/1ps
`include "spi_flash_config.svh"

module tb_spi_flash import bus_pkg::*, spi_flash_pkg::*; ();

	localparam int CYCLE_LIMIT = 25000;
	localparam int RANDOM_OPS = 40;
	localparam flash_byte_t READ_OPCODE = 8'h03;
	localparam flash_byte_t WAKE_OPCODE = 8'hab;

	logic CLK = 1'b0;
	logic RSTb;
	reg_addr_t address;
	reg_word_t data_in;
	reg_word_t data_out;
	logic wr;
	logic mosi;
	logic miso;
	logic sck;
	logic csb;
	int frame_count;
	flash_byte_t last_opcode;
	logic [23:0] last_addr;
	int last_bits;
	reg_word_t last_data;
	int cycles = 0;
	logic [31:0] seed = 32'hf868_6bca;

	spi_flash u_dut (
		.CLK(CLK),
		.RSTb(RSTb),
		.ADDRESS(address),
		.DATA_IN(data_in),
		.DATA_OUT(data_out),
		.WR(wr),
		.MOSI(mosi),
		.MISO(miso),
		.SCK(sck),
		.CSb(csb)
	);

	// memory fill runs on its own stream.
	flash_model #(.SEED(~32'hf868_6bca)) u_flash (
		.sck(sck),
		.csb(csb),
		.mosi(mosi),
		.miso(miso),
		.frame_count(frame_count),
		.last_opcode(last_opcode),
		.last_addr(last_addr),
		.last_bits(last_bits),
		.last_data(last_data)
	);

	always #2 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
			$display("sim failed");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s, got %h, expected %h",
				$time, msg, actual, expected);
			$display("sim failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// entered just after a falling edge.
	task automatic write_reg(input reg_addr_t a, input reg_word_t d);
		address = a;
		data_in = d;
		wr = 1'b1;
		@(negedge CLK);
		wr = 1'b0;
	endtask

	task automatic read_reg(input reg_addr_t a, output reg_word_t d);
		address = a;
		wr = 1'b0;
		#1;
		d = data_out;
		@(negedge CLK);
	endtask

	task automatic poll_done();
		reg_word_t status;
		status = '0;
		while (status[0] == 1'b0) begin
			read_reg(`REG_STATUS, status);
			if (status[1]) begin
				check(32'(status[0]), 32'd0, "done reads 0 while busy");
			end
		end
		read_reg(`REG_STATUS, status);
		check(32'(status), 32'd1, "done held with busy clear");
	endtask

	task automatic run_read(input word_addr_t wa, input logic both_bits);
		int frames_before;
		logic [31:0] r;
		reg_word_t result;
		frames_before = frame_count;
		r = $random(seed);
		write_reg(`REG_ADDR_LO, wa[15:0]);
		// upper bits of the high register are don't care.
		write_reg(`REG_ADDR_HI, {r[15:7], wa[22:16]});
		write_reg(`REG_CMD, {r[31:18], both_bits, 1'b1});
		poll_done();
		check(frame_count, frames_before + 1, "one frame per read");
		check(32'(last_opcode), 32'(READ_OPCODE), "read opcode");
		check(32'(last_addr), 32'(wa) * 32'd2, "byte address is twice the word address");
		check(last_bits, 32'd48, "read frame length");
		read_reg(`REG_DATA, result);
		check(32'(result), 32'(last_data), "read data with first byte low");
	endtask

	task automatic run_wake();
		int frames_before;
		logic [31:0] r;
		frames_before = frame_count;
		r = $random(seed);
		write_reg(`REG_CMD, {r[15:2], 2'b10});
		poll_done();
		check(frame_count, frames_before + 1, "one frame per wake");
		check(32'(last_opcode), 32'(WAKE_OPCODE), "wake opcode");
		check(last_bits, 32'd8, "wake frame length");
	endtask

	task automatic check_ignored_cmd(input word_addr_t wa);
		int frames_before;
		reg_word_t status;
		frames_before = frame_count;
		write_reg(`REG_ADDR_LO, wa[15:0]);
		write_reg(`REG_ADDR_HI, {9'd0, wa[22:16]});
		write_reg(`REG_CMD, 16'h0001);
		// start strobe still pending here.
		write_reg(`REG_CMD, 16'h0002);
		repeat (20) @(negedge CLK);
		write_reg(`REG_CMD, 16'h0002);
		poll_done();
		repeat (80) @(negedge CLK);
		read_reg(`REG_STATUS, status);
		check(32'(status), 32'd1, "idle and done after ignored commands");
		check(frame_count, frames_before + 1, "ignored commands add no frame");
		check(32'(last_opcode), 32'(READ_OPCODE), "frame is the accepted read");
		check(last_bits, 32'd48, "accepted read frame length");
	endtask

	initial begin
		reg_word_t value;
		logic [31:0] r;
		RSTb = 1'b0;
		address = '0;
		data_in = '0;
		wr = 1'b0;
		repeat (3) @(negedge CLK);
		RSTb = 1'b1;

		check(32'(csb), 32'd1, "CSb high after reset");
		check(32'(sck), 32'd0, "SCK low after reset");
		check(32'(mosi), 32'd0, "MOSI low after reset");
		read_reg(`REG_STATUS, value);
		check(32'(value), 32'd0, "status after reset");
		read_reg(`REG_DATA, value);
		check(32'(value), 32'd0, "data after reset");
		read_reg(8'h07, value);
		check(32'(value), 32'd0, "unused offset reads zero");
		check(frame_count, 32'd0, "no frame during reset");

		r = $random(seed);
		run_read(r[22:0], 1'b0);
		run_wake();
		r = $random(seed);
		check_ignored_cmd(r[22:0]);

		for (int i = 0; i < RANDOM_OPS; i++) begin
			r = $random(seed);
			if (r[31]) begin
				run_wake();
			end else begin
				run_read(r[22:0], r[30]);
			end
		end

		$display("sim passed");
		$finish;
	end

endmodule

/* spi_flash_reader.f */
+incdir+include
hw/bus_pkg.sv
hw/spi_flash_pkg.sv
hw/spi_flash_ifs.sv
hw/spi_regs.sv
hw/spi_sequencer.sv
hw/spi_bit_timer.sv
hw/spi_shifter.sv
hw/spi_flash.sv
tb/flash_model.sv
tb/tb_spi_flash.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SPI flash reader testbench with Verilator.
# A $fatal in the testbench gives a non-zero exit status.
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 \
	--top-module tb_spi_flash \
	-f spi_flash_reader.f \
	--Mdir obj_dir -o tb_spi_flash
./obj_dir/tb_spi_flash
